// File: common/autotest_pkg.sv
//##########################################################################
// shared types, record layout and sequencer states for the SD self-test
// controller. every RTL file pulls this in by wildcard import
//##########################################################################

package autotest_pkg;

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  sd_addr_t;
    typedef logic [127:0] vec_t;
    typedef logic [31:0]  cycles_t;
    typedef logic [9:0]   byte_off_t;

    // header as read from the first bytes of a block
    typedef struct packed {
        logic [31:0] signature;
        byte_t       iterations;
        vec_t        block;
        vec_t        key;
        logic        encdec;
    } hdr_t;

    typedef struct packed {
        vec_t    block_o;
        cycles_t cycles;
    } result_t;

    localparam int          BLOCK_BYTES  = 512;
    localparam logic [31:0] SIGNATURE_OK = 32'hAABBCCDD;

    // record byte offsets
    localparam byte_off_t OFF_ITER   = 10'd4;
    localparam byte_off_t OFF_BLOCK  = 10'd5;
    localparam byte_off_t OFF_KEY    = 10'd21;
    localparam byte_off_t OFF_ENCDEC = 10'd37;
    localparam byte_off_t OFF_RESULT = 10'd38;
    localparam byte_off_t OFF_CYCLES = 10'd54;
    localparam byte_off_t OFF_END    = 10'd58;

    typedef enum logic [3:0] {
        S_CLEAR, S_READ, S_WAIT_RD, S_CHECK, S_RUN,
        S_WRITE, S_WAIT_WR, S_ADVANCE, S_HALT
    } seq_state_t;

endpackage

// File: rtl/sd_block_reader.sv
//##########################################################################
// reads one SD block through the busy-based SPI host handshake and hands
// each byte on with its offset, as a single-cycle strobe
//##########################################################################
`timescale 1ns/1ns

module sd_block_reader
    import autotest_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  logic      spi_busy_i,
    input  byte_t     spi_data_i,
    output logic      spi_r_block_o,
    output logic      spi_r_byte_o,
    output logic      byte_stb_o,
    output byte_t     byte_o,
    output byte_off_t byte_off_o,
    output logic      done_o
);

    typedef enum logic [2:0] {
        R_IDLE, R_OPEN, R_OPEN_WAIT, R_REQ, R_WAIT
    } rd_state_t;

    rd_state_t state;
    byte_off_t cnt;
    logic      last_byte;

    assign last_byte = (cnt == byte_off_t'(BLOCK_BYTES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= R_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (start_i) begin
                        cnt   <= '0;
                        state <= R_OPEN;
                    end
                end
                R_OPEN: if (spi_busy_i) state <= R_OPEN_WAIT;
                R_OPEN_WAIT: if (!spi_busy_i) state <= R_REQ;
                R_REQ: if (spi_busy_i) state <= R_WAIT;
                R_WAIT: begin
                    if (!spi_busy_i) begin
                        if (last_byte) begin
                            state <= R_IDLE;
                        end else begin
                            cnt   <= cnt + 10'd1;
                            state <= R_REQ;
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    assign spi_r_block_o = (state != R_IDLE);
    assign spi_r_byte_o  = (state == R_REQ);

    // data is valid on the first cycle busy is seen low
    assign byte_stb_o = (state == R_WAIT) && !spi_busy_i;
    assign byte_o     = spi_data_i;
    assign byte_off_o = cnt;
    assign done_o     = byte_stb_o && last_byte;

endmodule

// File: rtl/vector_store.sv
//##########################################################################
// holds the header fields picked out of the incoming block by offset, and
// the UUT result with its cycle count until the record is written back
//##########################################################################
`timescale 1ns/1ns

module vector_store
    import autotest_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear_i,
    input  logic      byte_stb_i,
    input  byte_t     byte_i,
    input  byte_off_t byte_off_i,
    input  logic      res_stb_i,
    input  result_t   res_i,
    output hdr_t      hdr_o,
    output result_t   res_o
);

    logic [1:0] sig_idx;
    byte_off_t  blk_rel;
    byte_off_t  key_rel;

    // signature arrives most significant byte first
    assign sig_idx = 2'd3 - byte_off_i[1:0];
    assign blk_rel = byte_off_i - OFF_BLOCK;
    assign key_rel = byte_off_i - OFF_KEY;

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            hdr_o <= '0;
        end else if (byte_stb_i && (byte_off_i < OFF_END)) begin
            if (byte_off_i < OFF_ITER) begin
                hdr_o.signature[8*sig_idx +: 8] <= byte_i;
            end else if (byte_off_i == OFF_ITER) begin
                hdr_o.iterations <= byte_i;
            end else if (byte_off_i < OFF_KEY) begin
                hdr_o.block[8*blk_rel[3:0] +: 8] <= byte_i;
            end else if (byte_off_i < OFF_ENCDEC) begin
                hdr_o.key[8*key_rel[3:0] +: 8] <= byte_i;
            end else if (byte_off_i == OFF_ENCDEC) begin
                hdr_o.encdec <= byte_i[0];
            end
            // old result bytes in the block are not kept
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            res_o <= '0;
        end else if (res_stb_i) begin
            res_o <= res_i;
        end
    end

endmodule

// File: rtl/result_writer.sv
//##########################################################################
// writes the result record back to the SD block one byte per handshake.
// header echo, UUT output and cycle count, then zero fill to block end
//##########################################################################
`timescale 1ns/1ns

module result_writer
    import autotest_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start_i,
    input  hdr_t    hdr_i,
    input  result_t res_i,
    input  logic    spi_busy_i,
    output logic    spi_w_block_o,
    output logic    spi_w_byte_o,
    output byte_t   spi_data_o,
    output logic    done_o
);

    typedef enum logic [2:0] {
        W_IDLE, W_OPEN, W_OPEN_WAIT, W_REQ, W_WAIT
    } wr_state_t;

    wr_state_t state;
    byte_off_t cnt;
    logic      last_byte;

    assign last_byte = (cnt == byte_off_t'(BLOCK_BYTES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= W_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (start_i) begin
                        cnt   <= '0;
                        state <= W_OPEN;
                    end
                end
                // host pulses busy once for block setup
                W_OPEN: if (spi_busy_i) state <= W_OPEN_WAIT;
                W_OPEN_WAIT: if (!spi_busy_i) state <= W_REQ;
                W_REQ: if (spi_busy_i) state <= W_WAIT;
                W_WAIT: begin
                    if (!spi_busy_i) begin
                        if (last_byte) begin
                            state <= W_IDLE;
                        end else begin
                            cnt   <= cnt + 10'd1;
                            state <= W_REQ;
                        end
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // record byte for the current offset, steady while cnt holds
    always_comb begin
        logic [1:0] sig_idx;
        byte_off_t  rel;
        sig_idx    = 2'd3 - cnt[1:0];
        rel        = '0;
        spi_data_o = 8'h00;
        if (cnt < OFF_ITER) begin
            spi_data_o = hdr_i.signature[8*sig_idx +: 8];
        end else if (cnt == OFF_ITER) begin
            spi_data_o = hdr_i.iterations;
        end else if (cnt < OFF_KEY) begin
            rel        = cnt - OFF_BLOCK;
            spi_data_o = hdr_i.block[8*rel[3:0] +: 8];
        end else if (cnt < OFF_ENCDEC) begin
            rel        = cnt - OFF_KEY;
            spi_data_o = hdr_i.key[8*rel[3:0] +: 8];
        end else if (cnt == OFF_ENCDEC) begin
            spi_data_o = {7'd0, hdr_i.encdec};
        end else if (cnt < OFF_CYCLES) begin
            rel        = cnt - OFF_RESULT;
            spi_data_o = res_i.block_o[8*rel[3:0] +: 8];
        end else if (cnt < OFF_END) begin
            rel        = cnt - OFF_CYCLES;
            spi_data_o = res_i.cycles[8*rel[1:0] +: 8];
        end
    end

    assign spi_w_block_o = (state != W_IDLE);
    assign spi_w_byte_o  = (state == W_REQ);
    assign done_o        = (state == W_WAIT) && !spi_busy_i && last_byte;

endmodule

// File: rtl/test_sequencer.sv
//##########################################################################
// orders the phases of one test: clear, read, check, run, write, advance.
// owns UUT reset, the run-time cycle counter and the SD block address
//##########################################################################
`timescale 1ns/1ns

module test_sequencer
    import autotest_pkg::*;
#(
    parameter sd_addr_t START_BLOCK = 32'h0010_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        rd_done_i,
    input  logic        wr_done_i,
    input  logic [31:0] signature_i,
    input  logic        uut_done_i,
    input  vec_t        uut_block_i,
    output logic        rd_start_o,
    output logic        wr_start_o,
    output logic        clear_o,
    output logic        uut_rst_o,
    output logic        res_stb_o,
    output result_t     res_o,
    output sd_addr_t    block_addr_o
);

    seq_state_t state;
    cycles_t    cycle_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= S_CLEAR;
            cycle_cnt    <= '0;
            block_addr_o <= START_BLOCK;
        end else begin
            case (state)
                S_CLEAR: state <= S_READ;
                S_READ: state <= S_WAIT_RD;
                S_WAIT_RD: if (rd_done_i) state <= S_CHECK;
                S_CHECK: begin
                    cycle_cnt <= '0;
                    if (signature_i == SIGNATURE_OK) begin
                        state <= S_RUN;
                    end else begin
                        state <= S_HALT;
                    end
                end
                S_RUN: begin
                    cycle_cnt <= cycle_cnt + 32'd1;
                    if (uut_done_i) state <= S_WRITE;
                end
                S_WRITE: state <= S_WAIT_WR;
                S_WAIT_WR: if (wr_done_i) state <= S_ADVANCE;
                S_ADVANCE: begin
                    block_addr_o <= block_addr_o + 32'd1;
                    state        <= S_CLEAR;
                end
                // bad signature, wait here for rst
                S_HALT: state <= S_HALT;
                default: state <= S_CLEAR;
            endcase
        end
    end

    assign clear_o    = (state == S_CLEAR);
    assign rd_start_o = (state == S_READ);
    assign wr_start_o = (state == S_WRITE);

    // UUT runs only in S_RUN
    assign uut_rst_o = (state != S_RUN);

    // done cycle counts too, result latched on that same edge
    assign res_stb_o = (state == S_RUN) && uut_done_i;
    assign res_o     = '{block_o: uut_block_i, cycles: cycle_cnt + 32'd1};

endmodule

// File: rtl/autotest_ctrl.sv
//##########################################################################
// top level of the SD self-test controller. ties reader, store, writer
// and sequencer to the SPI host and to the UUT ports
//##########################################################################
`timescale 1ns/1ns

module autotest_ctrl
    import autotest_pkg::*;
#(
    parameter sd_addr_t START_BLOCK = 32'h0010_0000
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     spi_busy_i,
    input  byte_t    spi_data_i,
    output sd_addr_t spi_block_addr_o,
    output logic     spi_r_block_o,
    output logic     spi_r_byte_o,
    output logic     spi_w_block_o,
    output logic     spi_w_byte_o,
    output byte_t    spi_data_o,
    output logic     uut_rst_o,
    output vec_t     uut_block_o,
    output vec_t     uut_key_o,
    output logic     uut_encdec_o,
    input  vec_t     uut_block_i,
    input  logic     uut_done_i
);

    logic      rd_start, rd_done, wr_start, wr_done, clear;
    logic      byte_stb, res_stb;
    byte_t     rd_byte;
    byte_off_t byte_off;
    hdr_t      hdr;
    result_t   res_new, res;

    assign uut_block_o  = hdr.block;
    assign uut_key_o    = hdr.key;
    assign uut_encdec_o = hdr.encdec;

    sd_block_reader reader_i (
        .clk, .rst,
        .start_i       (rd_start),
        .spi_busy_i,
        .spi_data_i,
        .spi_r_block_o,
        .spi_r_byte_o,
        .byte_stb_o    (byte_stb),
        .byte_o        (rd_byte),
        .byte_off_o    (byte_off),
        .done_o        (rd_done)
    );

    vector_store store_i (
        .clk, .rst,
        .clear_i    (clear),
        .byte_stb_i (byte_stb),
        .byte_i     (rd_byte),
        .byte_off_i (byte_off),
        .res_stb_i  (res_stb),
        .res_i      (res_new),
        .hdr_o      (hdr),
        .res_o      (res)
    );

    result_writer writer_i (
        .clk, .rst,
        .start_i       (wr_start),
        .hdr_i         (hdr),
        .res_i         (res),
        .spi_busy_i,
        .spi_w_block_o,
        .spi_w_byte_o,
        .spi_data_o,
        .done_o        (wr_done)
    );

    test_sequencer #(.START_BLOCK(START_BLOCK)) seq_i (
        .clk, .rst,
        .rd_done_i    (rd_done),
        .wr_done_i    (wr_done),
        .signature_i  (hdr.signature),
        .uut_done_i,
        .uut_block_i,
        .rd_start_o   (rd_start),
        .wr_start_o   (wr_start),
        .clear_o      (clear),
        .uut_rst_o,
        .res_stb_o    (res_stb),
        .res_o        (res_new),
        .block_addr_o (spi_block_addr_o)
    );

endmodule

// File: tests/tb_autotest.sv
//##########################################################################
// testbench for the SD self-test controller. models the SPI host and the
// UUT, feeds three good blocks and one bad one, checks each written record
//##########################################################################
`timescale 1ns/1ns

module tb_autotest
    import autotest_pkg::*;
;

    localparam sd_addr_t START_BLOCK = 32'h0010_0000;
    localparam int NUM_BLOCKS  = 4;
    localparam int BYTE_LIMIT  = 100;
    localparam int IDLE_LIMIT  = 30000;

    logic     clk, rst, spi_busy_i, uut_done_i;
    byte_t    spi_data_i;
    vec_t     uut_block_i;
    sd_addr_t spi_block_addr_o;
    logic     spi_r_block_o, spi_r_byte_o, spi_w_block_o, spi_w_byte_o;
    byte_t    spi_data_o;
    logic     uut_rst_o, uut_encdec_o;
    vec_t     uut_block_o, uut_key_o;

    // per block header fields, and what the models saw
    logic [31:0] hdr_sig [0:NUM_BLOCKS-1];
    byte_t       hdr_iter [0:NUM_BLOCKS-1];
    vec_t        hdr_block [0:NUM_BLOCKS-1];
    vec_t        hdr_key [0:NUM_BLOCKS-1];
    logic        hdr_encdec [0:NUM_BLOCKS-1];
    cycles_t     run_cycles [0:NUM_BLOCKS-1];
    sd_addr_t    rd_addr_log [0:NUM_BLOCKS-1];
    byte_t       sd_mem [0:NUM_BLOCKS-1][0:511];
    byte_t       wr_rec [0:511];
    sd_addr_t    wr_addr;

    int seed = 32'h8c1d;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int rd_count = 0;
    int wr_count = 0;
    int compared = 0;
    int runs = 0;

    autotest_ctrl #(.START_BLOCK(START_BLOCK)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %-24s FAILED (%0d errors)", name, errors - errs_before);
        end else begin
            $display("test %-24s ok", name);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // filler for bytes the controller must ignore
    function automatic byte_t fill_byte(input int blk, input int off);
        int a;
        a = blk * 512 + off;
        return byte_t'(a ^ (a >> 7) ^ 8'hA5);
    endfunction

    // expected written record, straight from the record layout
    function automatic byte_t expected_record_byte(input int blk, input int off,
                                                   input cycles_t cyc);
        vec_t uout;
        uout = hdr_block[blk] ^ (hdr_encdec[blk] ? ~hdr_key[blk] : hdr_key[blk]);
        if (off < 4) return byte_t'(hdr_sig[blk] >> (8 * (3 - off)));
        if (off == 4) return hdr_iter[blk];
        if (off < 21) return byte_t'(hdr_block[blk] >> (8 * (off - 5)));
        if (off < 37) return byte_t'(hdr_key[blk] >> (8 * (off - 21)));
        if (off == 37) return {7'd0, hdr_encdec[blk]};
        if (off < 54) return byte_t'(uout >> (8 * (off - 38)));
        if (off < 58) return byte_t'(cyc >> (8 * (off - 54)));
        return 8'h00;
    endfunction

    task automatic build_block(input int b);
        for (int i = 0; i < 512; i++) sd_mem[b][i] = fill_byte(b, i);
        for (int i = 0; i < 4; i++) sd_mem[b][i] = hdr_sig[b][8*(3-i) +: 8];
        sd_mem[b][4] = hdr_iter[b];
        for (int i = 0; i < 16; i++) begin
            sd_mem[b][5+i]  = hdr_block[b][8*i +: 8];
            sd_mem[b][21+i] = hdr_key[b][8*i +: 8];
        end
        // upper bits of the encdec byte are junk
        sd_mem[b][37] = {7'b1010101, hdr_encdec[b]};
    endtask

    // SD host, follows the read and write block handshakes
    initial begin : sd_host
        int waited;
        int idx;
        sd_addr_t addr;
        bit is_wr;
        spi_busy_i = 1'b0;
        spi_data_i = 8'h00;
        next_cycle;
        forever begin
            waited = 0;
            while (!spi_r_block_o && !spi_w_block_o) begin
                if (waited == IDLE_LIMIT) abort_run("SD host saw no block request");
                next_cycle;
                waited++;
            end
            addr  = spi_block_addr_o;
            is_wr = spi_w_block_o;
            idx   = int'(addr - START_BLOCK);
            if (idx < 0 || idx >= NUM_BLOCKS) abort_run("block address outside SD model");
            // setup busy pulse opens the block
            spi_busy_i = 1'b1;
            repeat (rand_range(1, 6)) next_cycle;
            spi_busy_i = 1'b0;
            next_cycle;
            for (int i = 0; i < 512; i++) begin
                waited = 0;
                while (!(is_wr ? spi_w_byte_o : spi_r_byte_o)) begin
                    if (waited == BYTE_LIMIT) abort_run("no byte request from controller");
                    next_cycle;
                    waited++;
                end
                if (is_wr) begin
                    wr_rec[i] = spi_data_o;
                    check_value("spi_block_addr_o", 128'(addr), 128'(spi_block_addr_o));
                end
                spi_busy_i = 1'b1;
                repeat (rand_range(1, 6)) next_cycle;
                spi_busy_i = 1'b0;
                if (!is_wr) spi_data_i = sd_mem[idx][i];
                next_cycle;
            end
            if (is_wr) begin
                wr_addr = addr;
                wr_count++;
            end else begin
                if (rd_count < NUM_BLOCKS) rd_addr_log[rd_count] = addr;
                rd_count++;
            end
        end
    end

    // UUT model, XOR with key or inverted key
    initial begin : uut_model
        int run_len;
        int target;
        uut_done_i  = 1'b0;
        uut_block_i = '0;
        run_len     = 0;
        target      = 0;
        forever begin
            next_cycle;
            if (!uut_rst_o) begin
                if (run_len == 0) target = rand_range(3, 20);
                if (runs < NUM_BLOCKS) begin
                    check_value("uut_block_o", hdr_block[runs], uut_block_o);
                    check_value("uut_key_o", hdr_key[runs], uut_key_o);
                    check_value("uut_encdec_o", 128'(hdr_encdec[runs]), 128'(uut_encdec_o));
                end
                run_len++;
                if (run_len == target) begin
                    uut_done_i  = 1'b1;
                    uut_block_i = uut_block_o ^ (uut_encdec_o ? ~uut_key_o : uut_key_o);
                    if (runs < NUM_BLOCKS) run_cycles[runs] = cycles_t'(run_len);
                end
            end else begin
                if (run_len != 0) runs++;
                run_len    = 0;
                uut_done_i = 1'b0;
            end
        end
    end

    initial begin : compare_records
        int waited;
        int k;
        forever begin
            waited = 0;
            while (wr_count == compared) begin
                if (waited == IDLE_LIMIT) abort_run("no further record written");
                next_cycle;
                waited++;
            end
            k = compared;
            if (k >= NUM_BLOCKS - 1) begin
                errors++;
                $display("record written for block %0d, which has a bad signature", k);
            end else begin
                check_value("spi_block_addr_o", 128'(START_BLOCK + k), 128'(wr_addr));
                check_value("read block address", 128'(START_BLOCK + k), 128'(rd_addr_log[k]));
                for (int off = 0; off < 512; off++) begin
                    check_value($sformatf("spi_data_o byte %0d", off),
                                128'(expected_record_byte(k, off, run_cycles[k])),
                                128'(wr_rec[off]));
                end
            end
            compared++;
        end
    end

    initial begin : main
        int errs_before;
        int waited;
        bit saw_write;
        bit saw_run;
        rst = 1'b1;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            hdr_sig[b]    = (b < NUM_BLOCKS - 1) ? 32'hAABBCCDD : 32'hAABBCC0D;
            hdr_iter[b]   = byte_t'($random(seed));
            hdr_block[b]  = {$random(seed), $random(seed), $random(seed), $random(seed)};
            hdr_key[b]    = {$random(seed), $random(seed), $random(seed), $random(seed)};
            hdr_encdec[b] = (b == 1);
            build_block(b);
        end
        repeat (10) @(posedge clk);
        #2;
        errs_before = errors;
        check_value("spi_r_block_o", 128'(0), 128'(spi_r_block_o));
        check_value("spi_r_byte_o", 128'(0), 128'(spi_r_byte_o));
        check_value("spi_w_block_o", 128'(0), 128'(spi_w_block_o));
        check_value("spi_w_byte_o", 128'(0), 128'(spi_w_byte_o));
        check_value("uut_rst_o", 128'(1), 128'(uut_rst_o));
        check_value("spi_block_addr_o", 128'(START_BLOCK), 128'(spi_block_addr_o));
        finish_test("reset values", errs_before);
        rst = 1'b0;

        for (int k = 0; k < NUM_BLOCKS - 1; k++) begin
            errs_before = errors;
            waited = 0;
            while (compared < k + 1) begin
                if (waited == IDLE_LIMIT) abort_run($sformatf("no record for block %0d", k));
                next_cycle;
                waited++;
            end
            finish_test($sformatf("block %08h record", START_BLOCK + k), errs_before);
        end

        // bad signature, watch for 2000 cycles once its read is over
        errs_before = errors;
        waited = 0;
        while (rd_count < NUM_BLOCKS) begin
            if (waited == IDLE_LIMIT) abort_run("bad signature block was never read");
            next_cycle;
            waited++;
        end
        saw_write = 1'b0;
        saw_run   = 1'b0;
        repeat (2000) begin
            next_cycle;
            if (spi_w_block_o || spi_w_byte_o) saw_write = 1'b1;
            if (!uut_rst_o) saw_run = 1'b1;
        end
        if (saw_write) begin
            errors++;
            $display("controller requested a write after a bad signature");
        end
        if (saw_run) begin
            errors++;
            $display("UUT was released from reset after a bad signature");
        end
        finish_test("bad signature halt", errs_before);

        $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
common/autotest_pkg.sv
rtl/sd_block_reader.sv
rtl/vector_store.sv
rtl/result_writer.sv
rtl/test_sequencer.sv
rtl/autotest_ctrl.sv
tests/tb_autotest.sv

// File: Makefile
# Verilator build and run for the SD self-test controller testbench

VERILATOR ?= verilator
TOP       ?= tb_autotest
LOG       ?= sim.log
SEED      ?= 1
BUILD     ?= obj_dir
FLIST     ?= tb.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass if $(LOG) holds the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP LOG SEED BUILD FLIST"

test:
	$(VERILATOR) --binary --timing -Wno-fatal -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)
	$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
